/* sources.f */
+incdir+include
logic/l2_pkg.sv
logic/l2_tag_dirty_store.sv
logic/l2_data_store.sv
logic/l2_plru.sv
logic/l2_ctrl_fsm.sv
logic/l2_cache_top.sv
tb/tb_wb_mem.sv
tb/tb_l2_cache.sv

/* Bender.yml */
package:
  name: l2_cache

export_include_dirs:
  - include

sources:
  - files:
      - logic/l2_pkg.sv
      - logic/l2_tag_dirty_store.sv
      - logic/l2_data_store.sv
      - logic/l2_plru.sv
      - logic/l2_ctrl_fsm.sv
      - logic/l2_cache_top.sv
  - target: test
    files:
      - tb/tb_wb_mem.sv
      - tb/tb_l2_cache.sv

/* tb/tb_l2_cache.sv */
`include "l2_cfg.svh"

module tb_l2_cache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETS      = 1 << `L2_INDEX_W;
    localparam int MEM_WORDS = 1 << (`L2_ADDR_W - 2);
    localparam int NUM_OPS   = 340;    // upper bound over all tests

    logic               clk;
    logic               rstn;
    l2_pkg::wb_req_t    cpu_req;
    l2_pkg::wb_rsp_t    cpu_rsp;
    l2_pkg::wb_req_t    mem_req;
    l2_pkg::wb_rsp_t    mem_rsp;
    int                 mem_writes;
    int                 mem_reads;
    int                 seed;

    // reference model state
    l2_pkg::word_t      ref_mem  [MEM_WORDS];
    l2_pkg::word_t      ref_data [SETS][`L2_WAYS][`L2_WORDS];
    l2_pkg::tag_t       ref_tag  [SETS][`L2_WAYS];
    logic               ref_valid [SETS][`L2_WAYS];
    logic               ref_dirty [SETS][`L2_WAYS];
    logic [2:0]         ref_tree [SETS];

    l2_cache_top UUT (
        .clk, .rstn, .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp),
        .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    tb_wb_mem u_mem (
        .clk, .rstn, .req_i(mem_req), .rsp_o(mem_rsp),
        .writes_o(mem_writes), .reads_o(mem_reads)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_OPS * 40 + 8) @(posedge clk);
        $display("watchdog timeout, the cache stopped responding");
        $display(">>> FAIL");
        $fatal(1, "run aborted by watchdog");
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic l2_pkg::addr_t mk_addr(input l2_pkg::tag_t t, input l2_pkg::index_t i,
                                              input l2_pkg::offset_t o);
        return '{tag: t, index: i, offset: o, byte_off: 2'b00};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    task automatic model_access(input l2_pkg::addr_t a, input logic we, input l2_pkg::word_t wd,
                                output l2_pkg::word_t rd, output logic hit,
                                output int n_rd, output int n_wr);
        int way;
        logic [2:0] t;
        hit  = 1'b0;
        way  = 0;
        n_rd = 0;
        n_wr = 0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (ref_valid[a.index][w] && ref_tag[a.index][w] == a.tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        t = ref_tree[a.index];
        if (!hit) begin
            way = t[0] ? 2 + t[2] : t[1];   // zero walks to lower ways
            if (ref_valid[a.index][way] && ref_dirty[a.index][way]) begin
                for (int k = 0; k < `L2_WORDS; k++) begin
                    ref_mem[{ref_tag[a.index][way], a.index, l2_pkg::offset_t'(k)}] =
                        ref_data[a.index][way][k];
                end
                n_wr = `L2_WORDS;
            end
            for (int k = 0; k < `L2_WORDS; k++) begin
                ref_data[a.index][way][k] = ref_mem[{a.tag, a.index, l2_pkg::offset_t'(k)}];
            end
            n_rd = `L2_WORDS;
            ref_tag[a.index][way]   = a.tag;
            ref_valid[a.index][way] = 1'b1;
            ref_dirty[a.index][way] = 1'b0;
        end
        if (we) begin
            ref_data[a.index][way][a.offset] = wd;
            ref_dirty[a.index][way] = 1'b1;
        end
        rd = ref_data[a.index][way][a.offset];
        // root and leaf point away from the used way
        t[0] = (way < 2);
        if (way < 2) t[1] = (way == 0);
        else t[2] = (way == 2);
        ref_tree[a.index] = t;
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus access and directed tests
    //////////////////////////////////////////////////////////////////////

    // called 1 ns after a rising edge, returns 1 ns after the ack cycle
    task automatic cpu_access(input l2_pkg::addr_t a, input logic we, input l2_pkg::word_t wd,
                              output l2_pkg::word_t rd, output int cycles);
        cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: a, dat: wd};
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_rsp.ack);
        rd = cpu_rsp.dat;
        @(posedge clk);
        #1;
        cpu_req = '0;
    endtask

    task automatic do_op(input l2_pkg::addr_t a, input logic we, input l2_pkg::word_t wd,
                         output l2_pkg::word_t rd);
        l2_pkg::word_t exp_rd;
        logic exp_hit;
        int exp_rds, exp_wrs, rd0, wr0, cycles;
        model_access(a, we, wd, exp_rd, exp_hit, exp_rds, exp_wrs);
        rd0 = mem_reads;
        wr0 = mem_writes;
        cpu_access(a, we, wd, rd, cycles);
        if (!we) check("cpu_rsp_o.dat", rd, exp_rd);
        check("mem reads", mem_reads - rd0, exp_rds);
        check("mem writes", mem_writes - wr0, exp_wrs);
        if (exp_hit) check("hit ack cycles", cycles, 2);
    endtask

    task automatic idle_after_reset();
        repeat (6) begin
            @(negedge clk);
            check("cpu_rsp_o.ack", cpu_rsp.ack, 1'b0);
            check("mem_req_o.cyc", mem_req.cyc, 1'b0);
            check("mem_req_o.stb", mem_req.stb, 1'b0);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic read_miss_then_hits();
        l2_pkg::word_t rd;
        int rd0, wr0;
        rd0 = mem_reads;
        wr0 = mem_writes;
        do_op(mk_addr(8'h12, 3, 1), 1'b0, '0, rd);
        check("mem reads", mem_reads - rd0, 4);
        check("mem writes", mem_writes - wr0, 0);
        check("cpu_rsp_o.dat", rd, u_mem.image[{8'h12, 4'd3, 2'd1}]);
        rd0 = mem_reads;
        for (int k = 0; k < `L2_WORDS; k++) begin
            do_op(mk_addr(8'h12, 3, l2_pkg::offset_t'(3 - k)), 1'b0, '0, rd);
        end
        check("mem reads", mem_reads - rd0, 0);    // whole line now resident
    endtask

    task automatic write_miss_allocate();
        l2_pkg::word_t rd;
        int rd0, wr0;
        rd0 = mem_reads;
        wr0 = mem_writes;
        do_op(mk_addr(8'h34, 5, 2), 1'b1, 32'hdead_beef, rd);
        check("mem reads", mem_reads - rd0, 4);
        check("mem writes", mem_writes - wr0, 0);
        do_op(mk_addr(8'h34, 5, 2), 1'b0, '0, rd);
        check("cpu_rsp_o.dat", rd, 32'hdead_beef);
        for (int k = 0; k < `L2_WORDS; k++) begin
            if (k != 2) do_op(mk_addr(8'h34, 5, l2_pkg::offset_t'(k)), 1'b0, '0, rd);
        end
    endtask

    task automatic dirty_victim_eviction();
        l2_pkg::word_t rd;
        int wr0;
        do_op(mk_addr(8'h50, 7, 1), 1'b1, 32'hcafe_0001, rd);
        for (int t = 1; t < 4; t++) begin
            do_op(mk_addr(l2_pkg::tag_t'(8'h50 + t), 7, 0), 1'b0, '0, rd);
        end
        wr0 = mem_writes;
        do_op(mk_addr(8'h54, 7, 2), 1'b0, '0, rd);
        check("mem writes", mem_writes - wr0, 4);   // plru picks way 0, the dirty line
        do_op(mk_addr(8'h50, 7, 1), 1'b0, '0, rd);
        check("cpu_rsp_o.dat", rd, 32'hcafe_0001);
    endtask

    task automatic random_mix();
        l2_pkg::addr_t a;
        l2_pkg::word_t rd;
        for (int n = 0; n < 200; n++) begin
            a = mk_addr(l2_pkg::tag_t'(8'h40 + $urandom_range(5)),
                        l2_pkg::index_t'(8 + $urandom_range(2)),
                        l2_pkg::offset_t'($urandom_range(3)));
            do_op(a, 1'($urandom_range(1)), $urandom, rd);
        end
    endtask

    // dirty lines read through the cache, the rest straight from memory
    task automatic final_image_compare();
        l2_pkg::word_t rd;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (ref_valid[s][w] && ref_dirty[s][w]) begin
                    for (int k = 0; k < `L2_WORDS; k++) begin
                        do_op(mk_addr(ref_tag[s][w], l2_pkg::index_t'(s),
                                      l2_pkg::offset_t'(k)), 1'b0, '0, rd);
                    end
                end
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check("u_mem.image", u_mem.image[i], ref_mem[i]);
        end
    endtask

    initial begin
        seed    = 76562;
        void'($urandom(seed));
        rstn    = 1'b0;
        cpu_req = '0;
        for (int s = 0; s < SETS; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = u_mem.image[i];
        end
        idle_after_reset();
        read_miss_then_hits();
        write_miss_allocate();
        dirty_victim_eviction();
        random_mix();
        final_image_compare();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb/tb_wb_mem.sv */
`include "l2_cfg.svh"

module tb_wb_mem (
    input  logic                clk,
    input  logic                rstn,
    input  l2_pkg::wb_req_t     req_i,
    output l2_pkg::wb_rsp_t     rsp_o,
    output int                  writes_o,
    output int                  reads_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS = 1 << (`L2_ADDR_W - 2);

    l2_pkg::word_t              image [WORDS];
    logic [`L2_ADDR_W-3:0]      waddr;

    assign waddr = req_i.adr[`L2_ADDR_W-1:2];   // word address

    // both halves depend on the full word address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            image[i] = {16'(i) ^ 16'h3c5a, 16'(i) * 16'd7 + 16'h1000};
        end
    end

    // ack one cycle after stb, dropped for one cycle between beats
    always @(posedge clk) begin
        if (!rstn) begin
            rsp_o    <= '0;
            writes_o <= 0;
            reads_o  <= 0;
        end else if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
            rsp_o.ack <= 1'b1;
            if (req_i.we) begin
                image[waddr] <= req_i.dat;
                writes_o     <= writes_o + 1;
            end else begin
                rsp_o.dat <= image[waddr];
                reads_o   <= reads_o + 1;
            end
        end else begin
            rsp_o.ack <= 1'b0;
        end
    end

endmodule

/* logic/l2_cache_top.sv */
module l2_cache_top (
    input  logic                clk,
    input  logic                rstn,
    input  l2_pkg::wb_req_t     cpu_req_i,
    output l2_pkg::wb_rsp_t     cpu_rsp_o,
    output l2_pkg::wb_req_t     mem_req_o,
    input  l2_pkg::wb_rsp_t     mem_rsp_i
);

    l2_pkg::index_t     tag_index;
    l2_pkg::tag_t       tag;
    logic               fill;
    logic               fill_dirty;
    logic               set_dirty;
    l2_pkg::way_mask_t  hit_mask;
    l2_pkg::tag_t       victim_tag;
    logic               victim_dirty;
    l2_pkg::way_t       victim_way;
    logic               plru_touch;
    l2_pkg::way_t       plru_way;
    l2_pkg::index_t     line_index;
    logic               data_we;
    l2_pkg::way_t       data_way;
    l2_pkg::offset_t    data_offset;
    l2_pkg::word_t      data_wdata;
    l2_pkg::word_t      data_rdata;

    l2_ctrl_fsm u_fsm (
        .clk, .rstn, .cpu_req_i, .cpu_rsp_o, .mem_req_o, .mem_rsp_i,
        .tag_index_o(tag_index), .tag_o(tag), .fill_o(fill), .fill_dirty_o(fill_dirty),
        .set_dirty_o(set_dirty), .hit_mask_i(hit_mask), .victim_tag_i(victim_tag),
        .victim_dirty_i(victim_dirty), .victim_way_i(victim_way),
        .plru_touch_o(plru_touch), .plru_way_o(plru_way), .line_index_o(line_index),
        .data_we_o(data_we), .data_way_o(data_way), .data_offset_o(data_offset),
        .data_wdata_o(data_wdata), .data_rdata_i(data_rdata)
    );

    l2_tag_dirty_store u_tags (
        .clk, .rstn, .index_i(tag_index), .tag_i(tag), .victim_way_i(victim_way),
        .fill_i(fill), .fill_dirty_i(fill_dirty), .set_dirty_i(set_dirty),
        .hit_mask_o(hit_mask), .victim_tag_o(victim_tag), .victim_dirty_o(victim_dirty)
    );

    l2_data_store u_data (
        .clk, .index_i(line_index), .way_i(data_way), .offset_i(data_offset),
        .we_i(data_we), .wdata_i(data_wdata), .rdata_o(data_rdata)
    );

    l2_plru u_plru (
        .clk, .rstn, .index_i(line_index), .touch_i(plru_touch),
        .touch_way_i(plru_way), .victim_way_o(victim_way)
    );

endmodule

/* logic/l2_ctrl_fsm.sv */
`include "l2_cfg.svh"

module l2_ctrl_fsm (
    input  logic                clk,
    input  logic                rstn,
    // cpu side
    input  l2_pkg::wb_req_t     cpu_req_i,
    output l2_pkg::wb_rsp_t     cpu_rsp_o,
    // memory side
    output l2_pkg::wb_req_t     mem_req_o,
    input  l2_pkg::wb_rsp_t     mem_rsp_i,
    // tag store
    output l2_pkg::index_t      tag_index_o,
    output l2_pkg::tag_t        tag_o,
    output logic                fill_o,
    output logic                fill_dirty_o,
    output logic                set_dirty_o,
    input  l2_pkg::way_mask_t   hit_mask_i,
    input  l2_pkg::tag_t        victim_tag_i,
    input  logic                victim_dirty_i,
    // plru
    input  l2_pkg::way_t        victim_way_i,
    output logic                plru_touch_o,
    output l2_pkg::way_t        plru_way_o,
    // data store
    output l2_pkg::index_t      line_index_o,
    output logic                data_we_o,
    output l2_pkg::way_t        data_way_o,
    output l2_pkg::offset_t     data_offset_o,
    output l2_pkg::word_t       data_wdata_o,
    input  l2_pkg::word_t       data_rdata_i
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FINISH
    } state_e;

    state_e             state_q;
    l2_pkg::offset_t    cnt_q;      // beat counter, wraps after last word
    logic               req_we_q;
    l2_pkg::addr_t      req_adr_q;
    l2_pkg::word_t      req_dat_q;
    l2_pkg::way_t       hit_way;
    logic               hit;
    logic               last_word;

    assign hit       = |hit_mask_i;
    assign last_word = (cnt_q == l2_pkg::offset_t'(`L2_WORDS - 1));

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (hit_mask_i[w]) begin
                hit_way = l2_pkg::way_t'(w);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state and beat counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cpu_req_i.cyc && cpu_req_i.stb) state_q <= LOOKUP;
                end
                LOOKUP: begin
                    if (hit) state_q <= IDLE;
                    else if (victim_dirty_i) state_q <= WRITEBACK;
                    else state_q <= REFILL;
                end
                WRITEBACK: begin
                    if (mem_rsp_i.ack) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_word) state_q <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_rsp_i.ack) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_word) state_q <= FINISH;
                    end
                end
                FINISH: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // request capture, held while busy
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            req_we_q  <= cpu_req_i.we;
            req_adr_q <= cpu_req_i.adr;
            req_dat_q <= cpu_req_i.dat;
        end
    end

    // set read is synchronous, so idle looks up the incoming index
    assign tag_index_o  = (state_q == IDLE) ? cpu_req_i.adr.index : req_adr_q.index;
    assign tag_o        = req_adr_q.tag;
    assign line_index_o = req_adr_q.index;
    assign fill_dirty_o = req_we_q;

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cpu_rsp_o     = '0;
        cpu_rsp_o.dat = data_rdata_i;
        mem_req_o     = '0;
        fill_o        = 1'b0;
        set_dirty_o   = 1'b0;
        plru_touch_o  = 1'b0;
        plru_way_o    = victim_way_i;
        data_we_o     = 1'b0;
        data_way_o    = victim_way_i;
        data_offset_o = cnt_q;
        data_wdata_o  = mem_rsp_i.dat;
        case (state_q)
            LOOKUP: begin
                data_way_o    = hit_way;
                data_offset_o = req_adr_q.offset;
                data_wdata_o  = req_dat_q;
                plru_way_o    = hit_way;
                if (hit) begin
                    data_we_o     = req_we_q;
                    set_dirty_o   = req_we_q;
                    plru_touch_o  = 1'b1;
                    cpu_rsp_o.ack = 1'b1;
                end
            end
            WRITEBACK: begin
                mem_req_o.cyc = 1'b1;
                mem_req_o.stb = 1'b1;
                mem_req_o.we  = 1'b1;
                mem_req_o.adr = '{tag: victim_tag_i, index: req_adr_q.index,
                                  offset: cnt_q, byte_off: 2'b00};
                mem_req_o.dat = data_rdata_i;   // victim word at cnt
            end
            REFILL: begin
                mem_req_o.cyc = 1'b1;
                mem_req_o.stb = 1'b1;
                mem_req_o.adr = '{tag: req_adr_q.tag, index: req_adr_q.index,
                                  offset: cnt_q, byte_off: 2'b00};
                data_we_o     = mem_rsp_i.ack;
                if (req_we_q && (cnt_q == req_adr_q.offset)) begin
                    data_wdata_o = req_dat_q;   // write-allocate merge
                end
            end
            FINISH: begin
                fill_o        = 1'b1;
                plru_touch_o  = 1'b1;
                data_offset_o = req_adr_q.offset;
                cpu_rsp_o.ack = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* logic/l2_plru.sv */
`include "l2_cfg.svh"

module l2_plru (
    input  logic                clk,
    input  logic                rstn,
    input  l2_pkg::index_t      index_i,
    input  logic                touch_i,
    input  l2_pkg::way_t        touch_way_i,
    output l2_pkg::way_t        victim_way_o
);

    localparam int SETS = 1 << `L2_INDEX_W;

    // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
    logic [2:0] tree_q [SETS];
    logic [2:0] tree;

    assign tree = tree_q[index_i];

    // zero means take the lower half
    assign victim_way_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_i) begin
            tree_q[index_i][0] <= ~touch_way_i[1];     // root away from touched half
            if (touch_way_i[1]) begin
                tree_q[index_i][2] <= ~touch_way_i[0];
            end else begin
                tree_q[index_i][1] <= ~touch_way_i[0];
            end
        end
    end

endmodule

/* logic/l2_data_store.sv */
`include "l2_cfg.svh"

module l2_data_store (
    input  logic                clk,
    input  l2_pkg::index_t      index_i,
    input  l2_pkg::way_t        way_i,
    input  l2_pkg::offset_t     offset_i,
    input  logic                we_i,
    input  l2_pkg::word_t       wdata_i,
    output l2_pkg::word_t       rdata_o
);

    localparam int SETS = 1 << `L2_INDEX_W;

    // sets x ways x words
    l2_pkg::word_t mem [SETS][`L2_WAYS][`L2_WORDS];

    //////////////////////////////////////////////////////////////////////
    // one word per cycle, hits and refill beats alike
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[index_i][way_i][offset_i] <= wdata_i;
        end
    end

    // async read, also feeds writeback beats
    assign rdata_o = mem[index_i][way_i][offset_i];

endmodule

/* logic/l2_tag_dirty_store.sv */
`include "l2_cfg.svh"

module l2_tag_dirty_store (
    input  logic                clk,
    input  logic                rstn,
    input  l2_pkg::index_t      index_i,
    input  l2_pkg::tag_t        tag_i,
    input  l2_pkg::way_t        victim_way_i,
    input  logic                fill_i,
    input  logic                fill_dirty_i,
    input  logic                set_dirty_i,
    output l2_pkg::way_mask_t   hit_mask_o,
    output l2_pkg::tag_t        victim_tag_o,
    output logic                victim_dirty_o
);

    localparam int SETS = 1 << `L2_INDEX_W;

    l2_pkg::tag_t       tag_mem [SETS][`L2_WAYS];
    l2_pkg::way_mask_t  valid_q [SETS];
    l2_pkg::way_mask_t  dirty_q [SETS];

    l2_pkg::tag_t       rd_tag [`L2_WAYS];  // registered set readout
    l2_pkg::way_mask_t  rd_valid;
    l2_pkg::way_mask_t  rd_dirty;

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[index_i][victim_way_i] <= tag_i;
        end
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_tag[w] <= tag_mem[index_i][w];
        end
        rd_valid <= valid_q[index_i];
        rd_dirty <= dirty_q[index_i];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_i) begin
            valid_q[index_i][victim_way_i] <= 1'b1;
            dirty_q[index_i][victim_way_i] <= fill_dirty_i;
        end else if (set_dirty_i) begin
            dirty_q[index_i] <= dirty_q[index_i] | hit_mask_o;  // mask is one-hot
        end
    end

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            hit_mask_o[w] = rd_valid[w] && (rd_tag[w] == tag_i);
        end
    end

    assign victim_tag_o   = rd_tag[victim_way_i];
    assign victim_dirty_o = rd_valid[victim_way_i] & rd_dirty[victim_way_i];

endmodule

/* logic/l2_pkg.sv */
`include "l2_cfg.svh"

package l2_pkg;

    localparam int OFFSET_W = $clog2(`L2_WORDS);

    typedef logic [`L2_DATA_W-1:0] word_t;
    typedef logic [`L2_ADDR_W-`L2_INDEX_W-OFFSET_W-3:0] tag_t;
    typedef logic [`L2_INDEX_W-1:0] index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [1:0] way_t;
    typedef logic [`L2_WAYS-1:0] way_mask_t;

    // byte address, msb first
    typedef struct packed {
        tag_t         tag;
        index_t       index;
        offset_t      offset;
        logic [1:0]   byte_off;   // ignored, word accesses only
    } addr_t;

    // wishbone classic, master side
    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        addr_t  adr;
        word_t  dat;
    } wb_req_t;

    typedef struct packed {
        logic   ack;
        word_t  dat;
    } wb_rsp_t;

endpackage

/* include/l2_cfg.svh */
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

//////////////////////////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////////////////////////

`define L2_WAYS     4   // tree plru is built for 4
`define L2_INDEX_W  4   // 16 sets
`define L2_WORDS    4   // words per line

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define L2_ADDR_W   16
`define L2_DATA_W   32

`endif
